//--- Makefile
# Verilator build and run for the gamepad board testbench

TOP = gamepad_board_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; true
	cat sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/gamepad_board.sv
// Gamepad board top level
// Joins the gamepad peripheral to a mock controller on player 1 and holds
// the player 2 data line at its idle level

`include "pad_defs.svh"

module gamepad_board import pad_pkg::*; (
    input  logic                    clk_2x,
    input  logic                    reset,
    input  logic                    bus_valid,
    input  logic                    bus_write,
    input  logic [`PAD_ADDR_W-1:0]  bus_addr,
    input  logic [`PAD_DATA_W-1:0]  bus_wdata,
    input  logic [`PAD_BUTTONS-1:0] pad_btn,
    output logic [`PAD_DATA_W-1:0]  bus_rdata,
    output logic                    bus_rdata_valid,
    output logic                    irq,
    output logic                    pad_latch,
    output logic                    pad_clk
);

    pad_op_e    op;
    logic [1:0] pad_data;

    pad_scan_if scan_bus ();

    pad_reg_decode u_decode (
        .clk_2x    (clk_2x),
        .reset     (reset),
        .bus_valid (bus_valid),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .op        (op)
    );

    pad_scan_engine u_engine (
        .clk_2x    (clk_2x),
        .reset     (reset),
        .op        (op),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad_data  (pad_data),
        .scan      (scan_bus.engine)
    );

    pad_state_result u_result (
        .clk_2x          (clk_2x),
        .reset           (reset),
        .op              (op),
        .scan            (scan_bus.result),
        .bus_rdata       (bus_rdata),
        .bus_rdata_valid (bus_rdata_valid),
        .irq             (irq)
    );

    // Player 1 is driven from the button inputs
    mock_gamepad u_pad1 (
        .clk_2x    (clk_2x),
        .reset     (reset),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad_btn   (pad_btn),
        .pad_out   (pad_data[0])
    );

    // No controller on player 2, the pulled-up line reads as all released
    assign pad_data[1] = 1'b1;

endmodule

//--- design/mock_gamepad.sv
// Serial gamepad model
// Loads the button levels while latch is high and shifts them out MSB
// first on each pad_clk rising edge, seen in the clk_2x domain

`include "pad_defs.svh"

module mock_gamepad import pad_pkg::*; (
    input  logic         clk_2x,
    input  logic         reset,
    input  logic         pad_latch,
    input  logic         pad_clk,
    input  pad_buttons_t pad_btn,
    output logic         pad_out
);

    logic         pad_clk_d;
    logic         clk_rise;
    pad_buttons_t shift_reg;

    // pad_clk is a clk_2x-synchronous level, one delay is enough to find edges
    assign clk_rise = pad_clk && !pad_clk_d;

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            pad_clk_d <= 1'b0;
            shift_reg <= '0;
        end else begin
            pad_clk_d <= pad_clk;
            if (pad_latch) begin
                shift_reg <= pad_btn;
            end else if (clk_rise) begin
                // Zero fill, so reads past bit 12 look like released buttons
                shift_reg <= {shift_reg[`PAD_BUTTONS-2:0], 1'b0};
            end
        end
    end

    // Real pads pull the line low for a pressed button
    assign pad_out = ~shift_reg[`PAD_BUTTONS-1];

endmodule

//--- design/pad_defs.svh
// Gamepad peripheral constants
// Button count, serial clock divider and host bus widths shared by the
// package and the RTL modules

`ifndef PAD_DEFS_SVH
`define PAD_DEFS_SVH

// Buttons per controller, shifted out MSB first
`define PAD_BUTTONS 12

// clk_2x cycles per pad_clk half period, also the latch pulse length
// Must be 2 or more
`define PAD_CLK_DIV 4

// Host bus address width in bits
`define PAD_ADDR_W 2

// Host bus data width in bits
`define PAD_DATA_W 16

`endif

//--- design/pad_pkg.sv
// Gamepad peripheral package
// Opcode and scan state encodings plus the button and host word types

`include "pad_defs.svh"

package pad_pkg;

    // Operations issued by the host register decoder
    typedef enum logic [2:0] {
        OP_NONE        = 3'd0,
        OP_SCAN        = 3'd1,
        OP_CLEAR_EDGE  = 3'd2,
        OP_READ_STATUS = 3'd3,
        OP_READ_P1     = 3'd4,
        OP_READ_P2     = 3'd5,
        OP_READ_EDGE   = 3'd6
    } pad_op_e;

    // Scan engine states
    typedef enum logic [2:0] {
        S_IDLE     = 3'd0,
        S_LATCH    = 3'd1,
        S_CLK_LOW  = 3'd2,
        S_CLK_HIGH = 3'd3,
        S_DONE     = 3'd4
    } scan_state_e;

    // One bit per button, 1 is pressed, bit 11 leaves the controller first
    typedef logic [`PAD_BUTTONS-1:0] pad_buttons_t;

    // Host bus data word
    typedef logic [`PAD_DATA_W-1:0] pad_word_t;

endpackage

//--- design/pad_reg_decode.sv
// Host register decoder
// Turns each host bus strobe into one registered peripheral opcode,
// OP_NONE in every cycle without a strobe

`include "pad_defs.svh"

module pad_reg_decode import pad_pkg::*; (
    input  logic                   clk_2x,
    input  logic                   reset,
    input  logic                   bus_valid,
    input  logic                   bus_write,
    input  logic [`PAD_ADDR_W-1:0] bus_addr,
    input  logic [`PAD_DATA_W-1:0] bus_wdata,
    output pad_op_e                op
);

    // Register map
    localparam logic [`PAD_ADDR_W-1:0] ADDR_CTRL = `PAD_ADDR_W'(0);
    localparam logic [`PAD_ADDR_W-1:0] ADDR_P1   = `PAD_ADDR_W'(1);
    localparam logic [`PAD_ADDR_W-1:0] ADDR_P2   = `PAD_ADDR_W'(2);
    localparam logic [`PAD_ADDR_W-1:0] ADDR_EDGE = `PAD_ADDR_W'(3);

    pad_op_e op_next;

    always_comb begin
        op_next = OP_NONE;
        if (bus_valid) begin
            if (bus_write) begin
                // Only the control register is writable
                // The scan bit takes priority when both control bits are set
                if (bus_addr == ADDR_CTRL) begin
                    if (bus_wdata[0]) begin
                        op_next = OP_SCAN;
                    end else if (bus_wdata[1]) begin
                        op_next = OP_CLEAR_EDGE;
                    end
                end
            end else begin
                case (bus_addr)
                    ADDR_CTRL: op_next = OP_READ_STATUS;
                    ADDR_P1:   op_next = OP_READ_P1;
                    ADDR_P2:   op_next = OP_READ_P2;
                    ADDR_EDGE: op_next = OP_READ_EDGE;
                    default:   op_next = OP_NONE;
                endcase
            end
        end
    end

    // One cycle of decode latency, the opcode lives for exactly one cycle
    always_ff @(posedge clk_2x) begin
        if (reset) begin
            op <= OP_NONE;
        end else begin
            op <= op_next;
        end
    end

    // An idle bus cycle must never leave a stale opcode behind
    assert property (@(posedge clk_2x) disable iff (reset)
        !bus_valid |=> (op == OP_NONE))
        else $error("pad_reg_decode: opcode issued without a bus strobe");

endmodule

//--- design/pad_scan_engine.sv
// Gamepad scan engine
// Produces the latch pulse and the 12-bit pad_clk train, then deserializes
// the active-low data lines of both players into button vectors

`include "pad_defs.svh"

module pad_scan_engine import pad_pkg::*; (
    input  logic       clk_2x,
    input  logic       reset,
    input  pad_op_e    op,
    output logic       pad_latch,
    output logic       pad_clk,
    input  logic [1:0] pad_data,
    pad_scan_if.engine scan
);

    localparam int PHASE_W = $clog2(`PAD_CLK_DIV);
    localparam int BIT_W   = $clog2(`PAD_BUTTONS);

    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`PAD_CLK_DIV - 1);
    localparam logic [BIT_W-1:0]   BIT_LAST   = BIT_W'(`PAD_BUTTONS - 1);

    scan_state_e        state;
    logic [PHASE_W-1:0] phase_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    pad_buttons_t       p1_shift;
    pad_buttons_t       p2_shift;
    logic               phase_end;
    logic               sample;

    // A scan request is simply the decoded opcode
    assign scan.start = (op == OP_SCAN);

    assign phase_end = (phase_cnt == PHASE_LAST);

    // Data is taken in the last low cycle, well after the controller shifted
    assign sample = (state == S_CLK_LOW) && phase_end;

    // Serial lines follow the state directly
    assign pad_latch = (state == S_LATCH);
    assign pad_clk   = (state == S_CLK_HIGH);

    // Busy covers every non-idle state, so a start while busy is dropped
    assign scan.busy = (state != S_IDLE);

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            state     <= S_IDLE;
            phase_cnt <= '0;
            bit_cnt   <= '0;
            scan.done <= 1'b0;
        end else begin
            scan.done <= 1'b0;
            phase_cnt <= phase_end ? '0 : phase_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    phase_cnt <= '0;
                    bit_cnt   <= '0;
                    if (scan.start) begin
                        state <= S_LATCH;
                    end
                end
                S_LATCH: begin
                    if (phase_end) begin
                        state <= S_CLK_LOW;
                    end
                end
                S_CLK_LOW: begin
                    if (phase_end) begin
                        state <= S_CLK_HIGH;
                    end
                end
                S_CLK_HIGH: begin
                    if (phase_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        // Done is registered together with the move into S_DONE
                        if (bit_cnt == BIT_LAST) begin
                            state     <= S_DONE;
                            scan.done <= 1'b1;
                        end else begin
                            state <= S_CLK_LOW;
                        end
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Lines are active low, so a low level shifts in as a pressed button
    // The first bit sampled ends up in bit 11 after twelve shifts
    always_ff @(posedge clk_2x) begin
        if (sample) begin
            p1_shift <= {p1_shift[`PAD_BUTTONS-2:0], ~pad_data[0]};
            p2_shift <= {p2_shift[`PAD_BUTTONS-2:0], ~pad_data[1]};
        end
    end

    assign scan.p1_buttons = p1_shift;
    assign scan.p2_buttons = p2_shift;

    // Latch and clock overlapping would corrupt the controller's shift register
    assert property (@(posedge clk_2x) disable iff (reset)
        !(pad_latch && pad_clk))
        else $error("pad_scan_engine: latch and clock high together");

    // The registered done flag must line up with the state it announces
    assert property (@(posedge clk_2x) disable iff (reset)
        scan.done |-> (state == S_DONE))
        else $error("pad_scan_engine: done outside S_DONE");

    // A divider of 1 leaves no room to sample before the next shift
    assert property (@(posedge clk_2x) `PAD_CLK_DIV >= 2)
        else $error("pad_scan_engine: PAD_CLK_DIV must be at least 2");

endmodule

//--- design/pad_scan_if.sv
// Scan request and result bundle
// Carries the start pulse, busy flag, done pulse and both players'
// button vectors from the scan engine to the result block

interface pad_scan_if import pad_pkg::*; ();

    // One-cycle request, derived from OP_SCAN inside the engine
    logic start;

    // High from the cycle after an accepted start through the done cycle
    logic busy;

    // One-cycle pulse, button vectors are valid in this cycle only
    logic done;

    pad_buttons_t p1_buttons;
    pad_buttons_t p2_buttons;

    // The engine owns every signal, including the start it derives
    modport engine (
        output start,
        output busy,
        output done,
        output p1_buttons,
        output p2_buttons
    );

    // The result block only consumes the scan outcome
    modport result (
        input busy,
        input done,
        input p1_buttons,
        input p2_buttons
    );

endinterface

//--- design/pad_state_result.sv
// Gamepad result block
// Holds both players' button states, accumulates new player 1 presses
// into the edge register and interrupt, and answers host reads

module pad_state_result import pad_pkg::*; (
    input  logic       clk_2x,
    input  logic       reset,
    input  pad_op_e    op,
    pad_scan_if.result scan,
    output pad_word_t  bus_rdata,
    output logic       bus_rdata_valid,
    output logic       irq
);

    pad_buttons_t p1_state;
    pad_buttons_t p2_state;
    pad_buttons_t edge_bits;
    pad_buttons_t new_press;
    pad_word_t    read_word;
    logic         is_read;

    // Pressed now but released in the previous stored scan
    assign new_press = scan.p1_buttons & ~p1_state;

    assign is_read = (op == OP_READ_STATUS) || (op == OP_READ_P1) ||
                     (op == OP_READ_P2) || (op == OP_READ_EDGE);

    // Interrupt stays up while any new press is pending
    assign irq = |edge_bits;

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            p1_state  <= '0;
            p2_state  <= '0;
            edge_bits <= '0;
        end else begin
            if (scan.done) begin
                p1_state <= scan.p1_buttons;
                p2_state <= scan.p2_buttons;
            end
            // Presses landing with a clear are kept, older ones are dropped
            if (op == OP_CLEAR_EDGE) begin
                edge_bits <= scan.done ? new_press : '0;
            end else if (scan.done) begin
                edge_bits <= edge_bits | new_press;
            end
        end
    end

    // Upper bits of every word read back as zero
    always_comb begin
        case (op)
            OP_READ_STATUS: read_word = pad_word_t'({irq, scan.busy});
            OP_READ_P1:     read_word = pad_word_t'(p1_state);
            OP_READ_P2:     read_word = pad_word_t'(p2_state);
            OP_READ_EDGE:   read_word = pad_word_t'(edge_bits);
            default:        read_word = '0;
        endcase
    end

    // Read data only changes on a read, valid marks it for one cycle
    always_ff @(posedge clk_2x) begin
        if (is_read) begin
            bus_rdata <= read_word;
        end
    end

    always_ff @(posedge clk_2x) begin
        if (reset) begin
            bus_rdata_valid <= 1'b0;
        end else begin
            bus_rdata_valid <= is_read;
        end
    end

    // Back-to-back valid pulses need back-to-back read opcodes behind them
    assert property (@(posedge clk_2x) disable iff (reset)
        (bus_rdata_valid && $past(bus_rdata_valid)) |->
            ($past(is_read) && $past(is_read, 2)))
        else $error("pad_state_result: read data valid without a read");

endmodule

//--- flist.f
+incdir+design
design/pad_pkg.sv
design/pad_scan_if.sv
design/pad_reg_decode.sv
design/pad_scan_engine.sv
design/pad_state_result.sv
design/mock_gamepad.sv
design/gamepad_board.sv
testbench/gamepad_board_tb.sv

//--- testbench/gamepad_board_tb.sv
// Gamepad board testbench
// Directed tests for host register reads, scans of the mock controller,
// new-press accumulation, edge clearing and requests the design must ignore

`include "pad_defs.svh"

module gamepad_board_tb import pad_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // About 30 scans of roughly 130 cycles each, with margin
    localparam int CYCLE_LIMIT = 6000;

    logic                   clk_2x;
    logic                   reset;
    logic                   bus_valid;
    logic                   bus_write;
    logic [`PAD_ADDR_W-1:0] bus_addr;
    pad_word_t              bus_wdata;
    pad_buttons_t           pad_btn;
    pad_word_t              bus_rdata;
    logic                   bus_rdata_valid;
    logic                   irq;
    logic                   pad_latch;
    logic                   pad_clk;

    int   cycles = 0;
    int   latch_count = 0;
    logic latch_d = 1'b0;
    int   clk_count = 0;
    logic clk_d = 1'b0;
    int   errors = 0;
    int   checks = 0;

    // Expected player 1 state and pending new presses
    pad_buttons_t exp_p1 = '0;
    pad_buttons_t exp_edge = '0;

    gamepad_board uut (
        .clk_2x          (clk_2x),
        .reset           (reset),
        .bus_valid       (bus_valid),
        .bus_write       (bus_write),
        .bus_addr        (bus_addr),
        .bus_wdata       (bus_wdata),
        .pad_btn         (pad_btn),
        .bus_rdata       (bus_rdata),
        .bus_rdata_valid (bus_rdata_valid),
        .irq             (irq),
        .pad_latch       (pad_latch),
        .pad_clk         (pad_clk)
    );

    initial begin
        clk_2x = 1'b0;
        forever #4 clk_2x = ~clk_2x;
    end

    // Hard stop if some test never completes
    always @(posedge clk_2x) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Every latch rising edge marks one scan, every clock rising edge one bit shift
    always @(posedge clk_2x) begin
        latch_d <= pad_latch;
        clk_d   <= pad_clk;
        if (pad_latch && !latch_d) begin
            latch_count <= latch_count + 1;
        end
        if (pad_clk && !clk_d) begin
            clk_count <= clk_count + 1;
        end
    end

    task automatic check_word(input string what, input pad_word_t got, input pad_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_buttons(input string what, input pad_buttons_t got,
                                 input pad_buttons_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // All bus tasks start and end 1 ns after a rising edge
    task automatic write_reg(input logic [`PAD_ADDR_W-1:0] addr, input pad_word_t data);
        bus_valid = 1'b1;
        bus_write = 1'b1;
        bus_addr  = addr;
        bus_wdata = data;
        @(posedge clk_2x);
        #1;
        bus_valid = 1'b0;
        bus_write = 1'b0;
    endtask

    // Read data is due one cycle after the strobe edge, one decode and one result stage
    task automatic read_reg(input logic [`PAD_ADDR_W-1:0] addr, output pad_word_t data);
        int wait_cycles;
        bus_valid = 1'b1;
        bus_write = 1'b0;
        bus_addr  = addr;
        @(posedge clk_2x);
        #1;
        bus_valid = 1'b0;
        wait_cycles = 0;
        while (!bus_rdata_valid && wait_cycles < 8) begin
            @(posedge clk_2x);
            #1;
            wait_cycles++;
        end
        if (!bus_rdata_valid) begin
            errors++;
            $display("Read of address %0d returned no data within 8 cycles", addr);
        end else begin
            check_count("read data latency in cycles", wait_cycles, 1);
        end
        data = bus_rdata;
    endtask

    // Polls the status register until the engine drops busy
    task automatic wait_idle();
        pad_word_t status;
        int polls;
        polls = 0;
        do begin
            read_reg(2'd0, status);
            polls++;
        end while (status[0] && polls < 100);
        if (status[0]) begin
            errors++;
            $display("Scan never finished, busy still set after %0d status reads", polls);
        end
    endtask

    // Compares every readable register and irq with the expected state
    task automatic check_results(input string what);
        pad_word_t data;
        read_reg(2'd0, data);
        check_word({what, ": status"}, data, pad_word_t'({|exp_edge, 1'b0}));
        read_reg(2'd1, data);
        check_buttons({what, ": player 1"}, data[`PAD_BUTTONS-1:0], exp_p1);
        read_reg(2'd2, data);
        check_buttons({what, ": player 2"}, data[`PAD_BUTTONS-1:0], '0);
        read_reg(2'd3, data);
        check_buttons({what, ": new presses"}, data[`PAD_BUTTONS-1:0], exp_edge);
        check_flag({what, ": irq"}, irq, |exp_edge);
    endtask

    // New presses are buttons pressed now and released in the previous scan
    task automatic expect_scan(input pad_buttons_t buttons);
        exp_edge = exp_edge | (buttons & ~exp_p1);
        exp_p1   = buttons;
    endtask

    task automatic scan_and_check(input pad_buttons_t buttons, input string what);
        int latches_before;
        int clocks_before;
        latches_before = latch_count;
        clocks_before  = clk_count;
        pad_btn = buttons;
        expect_scan(buttons);
        write_reg(2'd0, 16'h0001);
        wait_idle();
        check_count({what, ": latch pulses"}, latch_count, latches_before + 1);
        check_count({what, ": clock pulses"}, clk_count, clocks_before + `PAD_BUTTONS);
        check_results(what);
    endtask

    task automatic clear_edges();
        write_reg(2'd0, 16'h0002);
        exp_edge = '0;
    endtask

    task automatic reset_state();
        check_results("after reset");
        check_count("latch pulses after reset", latch_count, 0);
        check_count("clock pulses after reset", clk_count, 0);
    endtask

    task automatic random_scans();
        repeat (10) begin
            scan_and_check(pad_buttons_t'($urandom), "random scan");
        end
    endtask

    task automatic press_accumulation();
        clear_edges();
        scan_and_check(12'h001, "accumulate 001");
        scan_and_check(12'h003, "accumulate 003");
        scan_and_check(12'h000, "accumulate 000");
        scan_and_check(12'h801, "accumulate 801");
        scan_and_check(12'hFFF, "accumulate FFF");
        scan_and_check(12'h7FE, "accumulate 7FE");
    endtask

    task automatic clear_and_rescan();
        clear_edges();
        check_results("after clear");
        // Releasing everything adds nothing, the next pattern must set bits again
        scan_and_check(12'h000, "released after clear");
        scan_and_check(12'hA5A, "pressed after clear");
    endtask

    task automatic busy_start_ignored();
        pad_word_t status;
        int latches_before;
        int clocks_before;
        latches_before = latch_count;
        clocks_before  = clk_count;
        pad_btn = 12'h3C5;
        expect_scan(12'h3C5);
        write_reg(2'd0, 16'h0001);
        // Move past the latch pulse so a restarted scan would latch a second time
        repeat (2 * `PAD_CLK_DIV) @(posedge clk_2x);
        #1;
        read_reg(2'd0, status);
        check_flag("busy after start", status[0], 1'b1);
        write_reg(2'd0, 16'h0001);
        wait_idle();
        check_count("latch pulses with a second start", latch_count, latches_before + 1);
        check_count("clock pulses with a second start", clk_count,
                    clocks_before + `PAD_BUTTONS);
        check_results("start while busy");
    endtask

    task automatic ignored_writes();
        int latches_before;
        latches_before = latch_count;
        write_reg(2'd1, 16'hFFFF);
        write_reg(2'd2, 16'hFFFF);
        write_reg(2'd3, 16'hFFFF);
        // Leave room for a latch pulse to show up if one was started
        repeat (4 * `PAD_CLK_DIV) @(posedge clk_2x);
        #1;
        check_count("latch pulses after ignored writes", latch_count, latches_before);
        check_results("after ignored writes");
    endtask

    initial begin
        reset     = 1'b1;
        bus_valid = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        pad_btn   = '0;
        void'($urandom(40));
        repeat (4) @(posedge clk_2x);
        #1;
        reset = 1'b0;

        reset_state();
        random_scans();
        clear_and_rescan();
        press_accumulation();
        busy_start_ignored();
        ignored_writes();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
